//--- common/eth_pkg.sv
package eth_pkg;

   // Frame buffer depth is 2**BUFFER_W bytes
   localparam int unsigned BUFFER_W = 11;

   // Register map, word index from byte address bits 4:2
   localparam logic [2:0] REG_CTRL    = 3'd0;
   localparam logic [2:0] REG_TX_LEN  = 3'd1;
   localparam logic [2:0] REG_STATUS  = 3'd2;
   localparam logic [2:0] REG_TX_DATA = 3'd3;
   localparam logic [2:0] REG_RX_DATA = 3'd4;

   // CTRL bits
   localparam int unsigned CTRL_CRC_EN = 0;
   localparam int unsigned CTRL_IRQ_EN = 1;

   // STATUS bits
   localparam int unsigned STAT_TX_BUSY    = 0;
   localparam int unsigned STAT_RX_DONE    = 1;
   localparam int unsigned STAT_CRC_ERR    = 2;
   localparam int unsigned STAT_TX_DONE    = 3;
   localparam int unsigned STAT_NBYTES_LSB = 16; // Rx byte count field

   // Frame framing
   localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0]  SFD_BYTE      = 8'hD5;
   localparam int unsigned PREAMBLE_LEN  = 7;

   // CRC-32, reflected form
   localparam logic [31:0] CRC_POLY    = 32'hEDB88320;
   localparam logic [31:0] CRC_INIT    = 32'hFFFFFFFF;
   localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B; // Good frame remainder, bit reversed

   // PHY reset stretch after core reset
   localparam int unsigned PHY_RST_CYCLES = 16;
   localparam int unsigned PHY_CNT_W      = $clog2(PHY_RST_CYCLES + 1);

endpackage

//--- common/eth_buf_if.sv
interface eth_buf_if;

   logic                         en;
   logic                         we;
   logic [eth_pkg::BUFFER_W-1:0] addr;
   logic [7:0]                   wdata;
   logic [7:0]                   rdata; // Valid one cycle after a read enable

   modport writer (
      output en,
      output we,
      output addr,
      output wdata,
      input  rdata
   );

   modport ram (
      input  en,
      input  we,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

//--- verilog/eth_frame_ram.sv
module eth_frame_ram (
   input  logic   clk_i,
   eth_buf_if.ram a_i,
   eth_buf_if.ram b_i
);

   logic [7:0] mem [2**eth_pkg::BUFFER_W];

   // Both ports in one block so the array has a single driver
   always_ff @(posedge clk_i) begin
      if (a_i.en) begin
         if (a_i.we) begin
            mem[a_i.addr] <= a_i.wdata;
         end else begin
            a_i.rdata <= mem[a_i.addr];
         end
      end
      if (b_i.en) begin
         if (b_i.we) begin
            mem[b_i.addr] <= b_i.wdata;
         end else begin
            b_i.rdata <= mem[b_i.addr];
         end
      end
   end

endmodule

//--- verilog/eth_crc32.sv
module eth_crc32 (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        init_i,
   input  logic        en_i,
   input  logic [3:0]  nib_i,
   output logic [31:0] crc_o
);

   logic [31:0] crc_nxt;

   // Four serial steps per nibble, LSB first
   always_comb begin
      crc_nxt = crc_o;
      for (int i = 0; i < 4; i++) begin
         if (crc_nxt[0] ^ nib_i[i]) begin
            crc_nxt = (crc_nxt >> 1) ^ eth_pkg::CRC_POLY;
         end else begin
            crc_nxt = crc_nxt >> 1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || init_i) begin
         crc_o <= eth_pkg::CRC_INIT;
      end else if (en_i) begin
         crc_o <= crc_nxt;
      end
   end

endmodule

//--- eth_tx/eth_tx.sv
module eth_tx (
   input  logic                         clk_i,
   input  logic                         rst_i,
   eth_buf_if.writer                    buf_o,
   input  logic                         send_i,
   input  logic [eth_pkg::BUFFER_W-1:0] tx_len_i,
   input  logic                         crc_en_i,
   output logic                         busy_o,
   output logic                         mtx_en_o,
   output logic [3:0]                   mtxd_o
);

   typedef enum logic [1:0] {
      IDLE,
      PRE,  // Preamble and SFD, 16 nibbles
      DATA,
      FCS
   } state_t;

   state_t                       state;
   logic [3:0]                   nib_cnt;
   logic                         hi;       // High nibble of current byte
   logic [eth_pkg::BUFFER_W-1:0] rd_addr;
   logic [eth_pkg::BUFFER_W-1:0] len_q;
   logic                         crc_q;
   logic [31:0]                  crc;
   logic [31:0]                  fcs;
   logic [7:0]                   pre_byte;
   logic                         start;

   assign start = (state == IDLE) && send_i;

   eth_crc32 crc_u (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .init_i (start),
      .en_i   (state == DATA),
      .nib_i  (mtxd_o),
      .crc_o  (crc)
   );

   // Read port only, address runs one byte ahead of the MII
   assign buf_o.en    = (state != IDLE);
   assign buf_o.we    = 1'b0;
   assign buf_o.addr  = rd_addr;
   assign buf_o.wdata = '0;

   always_ff @(posedge clk_i) begin
      if (start) begin
         len_q <= tx_len_i;
         crc_q <= crc_en_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state   <= IDLE;
         nib_cnt <= '0;
         hi      <= 1'b0;
         rd_addr <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (send_i) begin
                  state   <= PRE;
                  nib_cnt <= '0;
                  hi      <= 1'b0;
                  rd_addr <= '0;
               end
            end
            PRE: begin
               nib_cnt <= nib_cnt + 4'd1; // Wraps to 0 for FCS
               if (nib_cnt == 4'd15) begin
                  if (len_q != '0) begin
                     state <= DATA;
                  end else begin
                     state <= crc_q ? FCS : IDLE;
                  end
               end
            end
            DATA: begin
               hi <= ~hi;
               if (!hi) begin
                  rd_addr <= rd_addr + 1'b1; // Prefetch next byte
               end else if (rd_addr == len_q) begin
                  state <= crc_q ? FCS : IDLE;
               end
            end
            FCS: begin
               nib_cnt <= nib_cnt + 4'd1;
               if (nib_cnt == 4'd7) state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_comb begin
      pre_byte = (nib_cnt[3:1] == eth_pkg::PREAMBLE_LEN) ? eth_pkg::SFD_BYTE
                                                         : eth_pkg::PREAMBLE_BYTE;
      fcs      = ~crc;
      case (state)
         PRE:     mtxd_o = nib_cnt[0] ? pre_byte[7:4] : pre_byte[3:0];
         DATA:    mtxd_o = hi ? buf_o.rdata[7:4] : buf_o.rdata[3:0];
         FCS:     mtxd_o = fcs[{nib_cnt[2:0], 2'b00} +: 4]; // Low nibble first
         default: mtxd_o = 4'h0;
      endcase
   end

   assign mtx_en_o = (state != IDLE);
   assign busy_o   = (state != IDLE);

   a_no_send_busy: assert property (@(posedge clk_i) disable iff (rst_i)
      send_i |-> !busy_o)
      else $error("eth_tx: send while busy");

endmodule

//--- eth_rx/eth_rx.sv
module eth_rx (
   input  logic                         clk_i,
   input  logic                         rst_i,
   eth_buf_if.writer                    buf_o,
   input  logic                         mrx_dv_i,
   input  logic [3:0]                   mrxd_i,
   input  logic                         rcv_ack_i,
   output logic                         done_o,
   output logic [eth_pkg::BUFFER_W-1:0] nbytes_o,
   output logic                         crc_err_o
);

   typedef enum logic [1:0] {
      HUNT,
      DATA,
      LAST, // Latch count and CRC check
      DROP  // Skip a frame while done is pending
   } state_t;

   state_t                       state;
   logic                         saw5;
   logic                         hi;
   logic [3:0]                   low_nib;
   logic [eth_pkg::BUFFER_W-1:0] wr_addr;
   logic                         sfd_hit;
   logic                         wr_en;
   logic [31:0]                  crc;
   logic [31:0]                  crc_rev;

   assign sfd_hit = (state == HUNT) && !done_o && mrx_dv_i && saw5
                    && (mrxd_i == eth_pkg::SFD_BYTE[7:4]);
   assign wr_en   = (state == DATA) && mrx_dv_i && hi;

   assign buf_o.en    = wr_en;
   assign buf_o.we    = 1'b1;
   assign buf_o.addr  = wr_addr;
   assign buf_o.wdata = {mrxd_i, low_nib};

   eth_crc32 crc_u (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .init_i (sfd_hit),
      .en_i   ((state == DATA) && mrx_dv_i), // FCS nibbles included
      .nib_i  (mrxd_i),
      .crc_o  (crc)
   );

   assign crc_rev = {<<{crc}};

   always_ff @(posedge clk_i) begin
      if ((state == DATA) && mrx_dv_i && !hi) low_nib <= mrxd_i;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state     <= HUNT;
         saw5      <= 1'b0;
         hi        <= 1'b0;
         wr_addr   <= '0;
         done_o    <= 1'b0;
         crc_err_o <= 1'b0;
         nbytes_o  <= '0;
      end else begin
         saw5 <= (state == HUNT) && mrx_dv_i && (mrxd_i == eth_pkg::PREAMBLE_BYTE[3:0]);
         if (rcv_ack_i) begin
            done_o    <= 1'b0;
            crc_err_o <= 1'b0;
         end
         case (state)
            HUNT: begin
               if (mrx_dv_i && done_o) begin
                  state <= DROP;
               end else if (sfd_hit) begin
                  state   <= DATA;
                  wr_addr <= '0;
                  hi      <= 1'b0;
               end
            end
            DATA: begin
               if (mrx_dv_i) begin
                  hi <= ~hi;
                  if (hi) wr_addr <= wr_addr + 1'b1;
               end else begin
                  state <= LAST;
               end
            end
            LAST: begin
               done_o    <= 1'b1;
               nbytes_o  <= wr_addr;
               crc_err_o <= (crc_rev != eth_pkg::CRC_RESIDUE);
               state     <= HUNT;
            end
            DROP: if (!mrx_dv_i) state <= HUNT;
            default: state <= HUNT;
         endcase
      end
   end

   // Frame longer than the buffer would wrap the count
   a_no_wrap: assert property (@(posedge clk_i) disable iff (rst_i)
      wr_en |=> wr_addr != '0)
      else $error("eth_rx: byte count wrapped");

endmodule

//--- verilog/eth_regs.sv
module eth_regs (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         valid_i,
   input  logic [4:0]                   addr_i,
   input  logic [31:0]                  wdata_i,
   input  logic [3:0]                   wstrb_i,
   output logic [31:0]                  rdata_o,
   output logic                         rvalid_o,
   output logic                         ready_o,
   eth_buf_if.writer                    tx_buf_o,
   eth_buf_if.writer                    rx_buf_o,
   output logic                         send_o,
   output logic [eth_pkg::BUFFER_W-1:0] tx_len_o,
   output logic                         crc_en_o,
   input  logic                         tx_busy_i,
   input  logic                         rx_done_i,
   input  logic [eth_pkg::BUFFER_W-1:0] rx_nbytes_i,
   input  logic                         crc_err_i,
   output logic                         rcv_ack_o,
   output logic                         inta_o,
   output logic                         phy_rstn_o
);

   logic [2:0]                      idx;
   logic                            wr;
   logic                            rd;
   logic [1:0]                      ctrl;
   logic [eth_pkg::BUFFER_W-1:0]    tx_wptr;
   logic [eth_pkg::BUFFER_W-1:0]    rx_rptr;
   logic                            tx_done;
   logic                            busy_q;
   logic                            rx_sel_q; // Last read was RX_DATA
   logic [31:0]                     rdata_q;
   logic [31:0]                     status;
   logic [eth_pkg::PHY_CNT_W-1:0]   phy_cnt;

   assign idx     = addr_i[4:2];
   assign wr      = valid_i && (wstrb_i != 4'b0000);
   assign rd      = valid_i && (wstrb_i == 4'b0000);
   assign ready_o = 1'b1;

   always_comb begin
      status = '0;
      status[eth_pkg::STAT_TX_BUSY] = tx_busy_i;
      status[eth_pkg::STAT_RX_DONE] = rx_done_i;
      status[eth_pkg::STAT_CRC_ERR] = crc_err_i;
      status[eth_pkg::STAT_TX_DONE] = tx_done;
      status[eth_pkg::STAT_NBYTES_LSB +: eth_pkg::BUFFER_W] = rx_nbytes_i;
   end

   // Data windows onto the two frame buffers
   assign tx_buf_o.en    = wr && (idx == eth_pkg::REG_TX_DATA);
   assign tx_buf_o.we    = 1'b1;
   assign tx_buf_o.addr  = tx_wptr;
   assign tx_buf_o.wdata = wdata_i[7:0];

   assign rx_buf_o.en    = rd && (idx == eth_pkg::REG_RX_DATA);
   assign rx_buf_o.we    = 1'b0;
   assign rx_buf_o.addr  = rx_rptr;
   assign rx_buf_o.wdata = '0;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctrl      <= '0;
         tx_len_o  <= '0;
         send_o    <= 1'b0;
         rcv_ack_o <= 1'b0;
         tx_wptr   <= '0;
         rx_rptr   <= '0;
         tx_done   <= 1'b0;
         busy_q    <= 1'b0;
         rvalid_o  <= 1'b0;
         rx_sel_q  <= 1'b0;
      end else begin
         send_o    <= wr && (idx == eth_pkg::REG_TX_LEN);
         rcv_ack_o <= wr && (idx == eth_pkg::REG_STATUS) && wdata_i[eth_pkg::STAT_RX_DONE];
         busy_q    <= tx_busy_i;
         rvalid_o  <= rd;
         rx_sel_q  <= rx_buf_o.en;
         if (wr) begin
            case (idx)
               eth_pkg::REG_CTRL: ctrl <= wdata_i[1:0];
               eth_pkg::REG_TX_LEN: begin
                  tx_len_o <= wdata_i[eth_pkg::BUFFER_W-1:0];
                  tx_wptr  <= '0;
               end
               eth_pkg::REG_TX_DATA: tx_wptr <= tx_wptr + 1'b1;
               eth_pkg::REG_STATUS: begin
                  if (wdata_i[eth_pkg::STAT_RX_DONE]) rx_rptr <= '0;
                  if (wdata_i[eth_pkg::STAT_TX_DONE]) tx_done <= 1'b0;
               end
               default: ;
            endcase
         end
         if (rx_buf_o.en) rx_rptr <= rx_rptr + 1'b1;
         if (busy_q && !tx_busy_i) tx_done <= 1'b1; // Falling edge of busy
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd) begin
         case (idx)
            eth_pkg::REG_CTRL:    rdata_q <= {30'b0, ctrl};
            eth_pkg::REG_TX_LEN:  rdata_q <= {21'b0, tx_len_o};
            eth_pkg::REG_STATUS:  rdata_q <= status;
            eth_pkg::REG_TX_DATA: rdata_q <= {21'b0, tx_wptr};
            default:              rdata_q <= '0;
         endcase
      end
   end

   // RX_DATA comes straight from the RAM output register
   assign rdata_o = rx_sel_q ? {24'b0, rx_buf_o.rdata} : rdata_q;

   assign crc_en_o = ctrl[eth_pkg::CTRL_CRC_EN];
   assign inta_o   = ctrl[eth_pkg::CTRL_IRQ_EN] && (tx_done || rx_done_i);

   // PHY held in reset for a fixed count
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         phy_cnt <= eth_pkg::PHY_CNT_W'(eth_pkg::PHY_RST_CYCLES);
      end else if (phy_cnt != '0) begin
         phy_cnt <= phy_cnt - 1'b1;
      end
   end

   assign phy_rstn_o = (phy_cnt == '0);

   // Host reads RX_DATA only within a received frame
   a_rx_read_in_frame: assert property (@(posedge clk_i) disable iff (rst_i)
      rx_buf_o.en |-> rx_done_i && (rx_rptr < rx_nbytes_i))
      else $error("eth_regs: RX_DATA read outside the received frame");

endmodule

//--- verilog/eth_core.sv
module eth_core (
   input  logic        clk_i,
   input  logic        rst_i,

   // Host register bus
   input  logic        valid_i,
   input  logic [4:0]  addr_i,
   input  logic [31:0] wdata_i,
   input  logic [3:0]  wstrb_i,
   output logic [31:0] rdata_o,
   output logic        rvalid_o,
   output logic        ready_o,

   // MII
   output logic        mtx_en_o,
   output logic [3:0]  mtxd_o,
   input  logic        mrx_dv_i,
   input  logic [3:0]  mrxd_i,

   output logic        inta_o,
   output logic        phy_rstn_o
);

   logic                         send;
   logic [eth_pkg::BUFFER_W-1:0] tx_len;
   logic                         crc_en;
   logic                         tx_busy;
   logic                         rx_done;
   logic [eth_pkg::BUFFER_W-1:0] rx_nbytes;
   logic                         crc_err;
   logic                         rcv_ack;

   eth_buf_if tx_host ();  // Host fills tx buffer
   eth_buf_if tx_mac ();   // Transmitter reads it
   eth_buf_if rx_mac ();   // Receiver fills rx buffer
   eth_buf_if rx_host ();  // Host reads it back

   eth_regs regs (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .valid_i     (valid_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .rdata_o     (rdata_o),
      .rvalid_o    (rvalid_o),
      .ready_o     (ready_o),
      .tx_buf_o    (tx_host),
      .rx_buf_o    (rx_host),
      .send_o      (send),
      .tx_len_o    (tx_len),
      .crc_en_o    (crc_en),
      .tx_busy_i   (tx_busy),
      .rx_done_i   (rx_done),
      .rx_nbytes_i (rx_nbytes),
      .crc_err_i   (crc_err),
      .rcv_ack_o   (rcv_ack),
      .inta_o      (inta_o),
      .phy_rstn_o  (phy_rstn_o)
   );

   eth_frame_ram tx_buffer (
      .clk_i (clk_i),
      .a_i   (tx_host),
      .b_i   (tx_mac)
   );

   eth_frame_ram rx_buffer (
      .clk_i (clk_i),
      .a_i   (rx_mac),
      .b_i   (rx_host)
   );

   eth_tx tx (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .buf_o    (tx_mac),
      .send_i   (send),
      .tx_len_i (tx_len),
      .crc_en_i (crc_en),
      .busy_o   (tx_busy),
      .mtx_en_o (mtx_en_o),
      .mtxd_o   (mtxd_o)
   );

   eth_rx rx (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .buf_o     (rx_mac),
      .mrx_dv_i  (mrx_dv_i),
      .mrxd_i    (mrxd_i),
      .rcv_ack_i (rcv_ack),
      .done_o    (rx_done),
      .nbytes_o  (rx_nbytes),
      .crc_err_o (crc_err)
   );

endmodule

//--- testbench/eth_checker.sv
module eth_checker (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       valid_i,
   input  logic [3:0] wstrb_i,
   input  logic       rvalid_i,
   input  logic       mtx_en_i,
   input  logic [3:0] mtxd_i,
   output int         errors_o
);
   timeunit 1ns;
   timeprecision 1ps;

   int         errors = 0;
   int         checks = 0;
   int         tests = 0;
   int         test_base = 0;    // Error count when the current test began
   logic       rd_pending = 1'b0;
   logic [7:0] frm [$];          // Payload of the frame being modelled
   logic [3:0] exp_nibs [$];
   int         exp_lens [$];     // Nibbles per expected frame
   logic [3:0] got_nibs [$];

   assign errors_o = errors;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic fail(input string msg);
      errors++;
      $display("ERROR: %s", msg);
   endtask

   task automatic new_frame();
      frm.delete();
   endtask

   task automatic add_byte(input logic [7:0] b);
      frm.push_back(b);
   endtask

   // Reference CRC-32, bit by bit over each byte, LSB first
   function automatic logic [31:0] fcs();
      logic [31:0] c;
      c = eth_pkg::CRC_INIT;
      foreach (frm[i]) begin
         for (int b = 0; b < 8; b++) begin
            if (c[0] ^ frm[i][b]) begin
               c = (c >> 1) ^ eth_pkg::CRC_POLY;
            end else begin
               c = c >> 1;
            end
         end
      end
      return ~c;
   endfunction

   task automatic push_byte(input logic [7:0] b);
      exp_nibs.push_back(b[3:0]); // Low nibble goes out first
      exp_nibs.push_back(b[7:4]);
   endtask

   task automatic expect_tx(input logic crc_on);
      logic [31:0] f;
      for (int i = 0; i < 8; i++) begin
         push_byte((i == 7) ? eth_pkg::SFD_BYTE : eth_pkg::PREAMBLE_BYTE);
      end
      foreach (frm[i]) push_byte(frm[i]);
      if (crc_on) begin
         f = fcs();
         for (int k = 0; k < 4; k++) push_byte(f[8*k +: 8]);
      end
      exp_lens.push_back(2 * (8 + frm.size() + (crc_on ? 4 : 0)));
   endtask

   task automatic compare_frame();
      int         n;
      int         bad;
      logic [3:0] e;
      if (exp_lens.size() == 0) begin
         fail("transmitter sent a frame that was never requested");
         return;
      end
      n   = exp_lens.pop_front();
      bad = -1;
      check("mtx_en_o cycles", got_nibs.size(), n);
      for (int i = 0; i < n; i++) begin
         e = exp_nibs.pop_front();
         if (bad < 0 && i < got_nibs.size() && got_nibs[i] !== e) begin
            bad = i;  // Report only the first wrong nibble
            errors++;
            $display("MISMATCH mtxd_o nibble %0d: got %h, expected %h", i, got_nibs[i], e);
         end
      end
      checks++;
   endtask

   // Collect each transmitted frame while mtx_en is high
   always @(negedge clk_i) begin
      if (rst_i) begin
         got_nibs.delete();
      end else if (mtx_en_i) begin
         got_nibs.push_back(mtxd_i);
      end else if (got_nibs.size() != 0) begin
         compare_frame();
         got_nibs.delete();
      end
   end

   // Read response one cycle after each read
   always @(posedge clk_i) rd_pending <= valid_i && (wstrb_i == 4'h0) && !rst_i;

   always @(negedge clk_i) begin
      if (!rst_i && (rd_pending || rvalid_i)) check("rvalid_o", rvalid_i, rd_pending);
   end

   task automatic end_test(input string name);
      tests++;
      if (errors == test_base) begin
         $display("Test %s passed", name);
      end else begin
         $display("Test %s failed with %0d errors", name, errors - test_base);
      end
      test_base = errors;
   endtask

   task automatic report();
      if (exp_lens.size() != 0) fail("an expected transmit frame never appeared");
      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
   endtask

endmodule

//--- testbench/tb_eth_core.sv
module tb_eth_core;
   timeunit 1ns;
   timeprecision 1ps;

   // Frames 0 and 1 tx only, 2 to 4 loopback, 5 to 7 injected, 8 interrupt
   localparam int NUM_FRAMES = 9;

   logic        clk;
   logic        rst;
   logic        valid;
   logic [4:0]  addr;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic [31:0] rdata;
   logic        rvalid;
   logic        ready;
   logic        mtx_en;
   logic [3:0]  mtxd;
   logic        mrx_dv;
   logic [3:0]  mrxd;
   logic        inta;
   logic        phy_rstn;
   int          errors;
   logic        loopback;
   int          lens [NUM_FRAMES];
   int          limit;
   int          cycles = 0;
   logic [7:0]  pay [$];
   logic [7:0]  wire_q [$];  // Bytes after the SFD, FCS included

   eth_core UUT (
      .clk_i      (clk),
      .rst_i      (rst),
      .valid_i    (valid),
      .addr_i     (addr),
      .wdata_i    (wdata),
      .wstrb_i    (wstrb),
      .rdata_o    (rdata),
      .rvalid_o   (rvalid),
      .ready_o    (ready),
      .mtx_en_o   (mtx_en),
      .mtxd_o     (mtxd),
      .mrx_dv_i   (mrx_dv),
      .mrxd_i     (mrxd),
      .inta_o     (inta),
      .phy_rstn_o (phy_rstn)
   );

   eth_checker chk (
      .clk_i    (clk),
      .rst_i    (rst),
      .valid_i  (valid),
      .wstrb_i  (wstrb),
      .rvalid_i (rvalid),
      .mtx_en_i (mtx_en),
      .mtxd_i   (mtxd),
      .errors_o (errors)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(negedge clk) begin
      if (loopback) begin
         mrx_dv = mtx_en;
         mrxd   = mtxd;
      end
   end

   task automatic bus_write(input logic [2:0] idx, input logic [31:0] data);
      valid = 1'b1;
      addr  = {idx, 2'b00};
      wdata = data;
      wstrb = 4'hF;
      @(negedge clk);
      valid = 1'b0;
      wstrb = 4'h0;
   endtask

   task automatic bus_read(input logic [2:0] idx, output logic [31:0] data);
      valid = 1'b1;
      addr  = {idx, 2'b00};
      wstrb = 4'h0;
      @(negedge clk);
      valid = 1'b0;
      data  = rdata;  // rvalid is high in this cycle
   endtask

   task automatic wait_flag(input int bit_pos, input string what);
      logic [31:0] st;
      int          n;
      n = 0;
      bus_read(eth_pkg::REG_STATUS, st);
      while (!st[bit_pos] && n < 400) begin
         bus_read(eth_pkg::REG_STATUS, st);
         n++;
      end
      if (!st[bit_pos]) chk.fail({"status never showed ", what});
   endtask

   task automatic make_payload(input int len);
      logic [7:0] b;
      pay.delete();
      chk.new_frame();
      for (int i = 0; i < len; i++) begin
         b = 8'($urandom);
         pay.push_back(b);
         chk.add_byte(b);
      end
   endtask

   task automatic send_frame(input int len, input logic crc_on);
      make_payload(len);
      foreach (pay[i]) bus_write(eth_pkg::REG_TX_DATA, {24'b0, pay[i]});
      chk.expect_tx(crc_on);
      bus_write(eth_pkg::REG_TX_LEN, len);
   endtask

   task automatic build_wire();
      logic [31:0] f;
      f = chk.fcs();
      wire_q = pay;
      for (int k = 0; k < 4; k++) wire_q.push_back(f[8*k +: 8]);
   endtask

   task automatic flip_bit(input int sel);
      logic [7:0] b;
      b = wire_q[sel / 8];
      b[sel % 8] = ~b[sel % 8];
      wire_q[sel / 8] = b;
   endtask

   task automatic inject_wire();
      for (int i = 0; i < 16; i++) begin
         mrx_dv = 1'b1;
         mrxd   = (i == 15) ? eth_pkg::SFD_BYTE[7:4] : eth_pkg::PREAMBLE_BYTE[3:0];
         @(negedge clk);
      end
      foreach (wire_q[i]) begin
         mrxd = wire_q[i][3:0];
         @(negedge clk);
         mrxd = wire_q[i][7:4];
         @(negedge clk);
      end
      mrx_dv = 1'b0;
      mrxd   = 4'h0;
   endtask

   task automatic check_rx(input int len, input logic crc_bad);
      logic [31:0] st;
      bus_read(eth_pkg::REG_STATUS, st);
      chk.check("STATUS rx_done", st[eth_pkg::STAT_RX_DONE], 1);
      chk.check("STATUS crc_err", st[eth_pkg::STAT_CRC_ERR], crc_bad);
      chk.check("STATUS nbytes", st[26:16], len + 4);
   endtask

   task automatic read_back();
      logic [31:0] d;
      foreach (wire_q[i]) begin
         bus_read(eth_pkg::REG_RX_DATA, d);
         chk.check("rdata_o", d, {24'b0, wire_q[i]});
      end
   endtask

   task automatic ack();
      logic [31:0] st;
      bus_write(eth_pkg::REG_STATUS, 32'h0000_000A); // Rx ack and tx done clear
      @(negedge clk);
      bus_read(eth_pkg::REG_STATUS, st);
      chk.check("STATUS flags", st[3:0], 0);
      chk.check("inta_o", inta, 0);
   endtask

   initial begin
      logic [31:0] st;
      int          seed_val;
      int          n;
      seed_val = $urandom(21);
      rst      = 1'b1;
      valid    = 1'b0;
      addr     = '0;
      wdata    = '0;
      wstrb    = '0;
      mrx_dv   = 1'b0;
      mrxd     = '0;
      loopback = 1'b0;
      limit    = 200;
      foreach (lens[i]) begin
         lens[i] = 1 + ($urandom % 64);
         limit += 2 * (12 + lens[i]) + 50; // Frame time plus host traffic
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      chk.check("mtx_en_o", mtx_en, 0);
      chk.check("inta_o", inta, 0);
      chk.check("rvalid_o", rvalid, 0);
      chk.check("ready_o", ready, 1);
      n = 0;
      while (!phy_rstn && n < 100) begin
         @(negedge clk);
         n++;
      end
      chk.check("phy_rstn_o low cycles", n, eth_pkg::PHY_RST_CYCLES);
      bus_read(eth_pkg::REG_STATUS, st);
      chk.check("STATUS", st, 0);
      chk.end_test("reset");

      bus_write(eth_pkg::REG_CTRL, 32'h3);
      send_frame(lens[0], 1'b1);
      wait_flag(eth_pkg::STAT_TX_DONE, "tx done");
      bus_read(eth_pkg::REG_STATUS, st);
      chk.check("STATUS", st, 32'h8);
      chk.check("inta_o", inta, 1);
      bus_write(eth_pkg::REG_STATUS, 32'h8);
      chk.check("inta_o", inta, 0);
      chk.end_test("tx_crc");

      bus_write(eth_pkg::REG_CTRL, 32'h2);
      send_frame(lens[1], 1'b0);       // Checker expects no FCS
      wait_flag(eth_pkg::STAT_TX_DONE, "tx done");
      chk.check("inta_o", inta, 1);
      bus_write(eth_pkg::REG_STATUS, 32'h8);
      chk.end_test("tx_nocrc");

      bus_write(eth_pkg::REG_CTRL, 32'h3);
      loopback = 1'b1;
      for (int f = 2; f < 5; f++) begin
         send_frame(lens[f], 1'b1);
         build_wire();
         wait_flag(eth_pkg::STAT_RX_DONE, "rx done");
         check_rx(lens[f], 1'b0);
         read_back();
         ack();
      end
      loopback = 1'b0;
      mrx_dv   = 1'b0;
      chk.end_test("loopback");

      make_payload(lens[5]);
      build_wire();
      flip_bit($urandom % (wire_q.size() * 8));
      inject_wire();
      wait_flag(eth_pkg::STAT_RX_DONE, "rx done");
      check_rx(lens[5], 1'b1);
      make_payload(lens[6]);
      build_wire();
      inject_wire();                   // Dropped while done is pending
      repeat (4) @(negedge clk);       // Done would follow two cycles after dv falls
      check_rx(lens[5], 1'b1);
      ack();
      make_payload(lens[7]);
      build_wire();
      inject_wire();
      wait_flag(eth_pkg::STAT_RX_DONE, "rx done");
      check_rx(lens[7], 1'b0);
      read_back();
      ack();
      chk.end_test("corrupt");

      bus_write(eth_pkg::REG_CTRL, 32'h1);  // IRQ_EN clear
      send_frame(lens[8], 1'b1);
      wait_flag(eth_pkg::STAT_TX_DONE, "tx done");
      chk.check("inta_o", inta, 0);
      bus_write(eth_pkg::REG_CTRL, 32'h3);
      chk.check("inta_o", inta, 1);
      ack();
      chk.end_test("irq");

      @(negedge clk);
      chk.report();
      @(negedge clk);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin
      do begin
         @(posedge clk);
         cycles++;
      end while (cycles < limit);
      $display("Timeout: run did not end within %0d cycles", limit);
      $display("Finished with errors");
      $finish;
   end

endmodule

//--- compile.f
common/eth_pkg.sv
common/eth_buf_if.sv
verilog/eth_frame_ram.sv
verilog/eth_crc32.sv
eth_tx/eth_tx.sv
eth_rx/eth_rx.sv
verilog/eth_regs.sv
verilog/eth_core.sv
testbench/eth_checker.sv
testbench/tb_eth_core.sv

//--- Bender.yml
package:
  name: eth_core

sources:
  - common/eth_pkg.sv
  - common/eth_buf_if.sv
  - verilog/eth_frame_ram.sv
  - verilog/eth_crc32.sv
  - eth_tx/eth_tx.sv
  - eth_rx/eth_rx.sv
  - verilog/eth_regs.sv
  - verilog/eth_core.sv
  - target: simulation
    files:
      - testbench/eth_checker.sv
      - testbench/tb_eth_core.sv
